// ==== verilog/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

  localparam int xlen          = 32;
  localparam int bp_index_bits = 8;
  localparam int bp_entries    = 256;
  localparam int bp_tag_bits   = 22;
  localparam int bp_index_lsb  = 2;   // pc[9:2] selects the entry
  localparam int bp_tag_lsb    = bp_index_lsb + bp_index_bits;   // pc[31:10] is the tag

  localparam logic [6:0] opcode_branch = 7'b1100011;   // beq, bne, blt, bge, bltu, bgeu

  typedef logic [bp_index_bits-1:0] bp_index_t;

  // two-bit saturating counter with hysteresis
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } bp_state_t;

  typedef struct packed {
    logic                   valid;
    logic [bp_tag_bits-1:0] tag;
    logic [xlen-1:0]        target;
  } btb_entry_t;

  // decode stage request
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [6:0]      opcode;
  } decode_req_t;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;   // pc + 4 when not taken
  } prediction_t;

  // execute stage outcome, pred_* travelled down with the instruction
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic            is_branch;
    logic            actual_taken;
    logic [xlen-1:0] actual_target;
    logic            pred_taken;
    logic [xlen-1:0] pred_target;
  } exec_resolve_t;

  typedef struct packed {
    logic            flush;
    logic [xlen-1:0] pc;
  } redirect_t;

endpackage

`default_nettype wire

// ==== verilog/bp_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module bp_table import bp_pkg::*; #(
  parameter type entry_t  = bp_state_t,
  parameter int  rd_ports = 1
) (
  input  wire logic      clk,
  input  wire logic      arst_n,
  input  bp_index_t      rd_index [rd_ports],
  output entry_t         rd_entry [rd_ports],
  input  wire logic      wr_en,
  input  bp_index_t      wr_index,
  input  entry_t         wr_entry,
  input  wire logic      clr_en,
  input  bp_index_t      clr_index
);

  localparam entry_t zero_entry = entry_t'('0);

  entry_t mem [bp_entries];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < bp_entries; i++) begin
        mem[i] <= zero_entry;   // invalid / strong_not_taken
      end
    end else if (clr_en) begin
      mem[clr_index] <= zero_entry;   // sweep wins over update
    end else if (wr_en) begin
      mem[wr_index] <= wr_entry;
    end
  end

  // combinational read ports
  for (genvar p = 0; p < rd_ports; p++) begin : g_rd
    assign rd_entry[p] = mem[rd_index[p]];
  end

endmodule

`default_nettype wire

// ==== verilog/bp_lookup.sv ====
`timescale 1ns/100ps
`default_nettype none

module bp_lookup import bp_pkg::*; (
  input  decode_req_t  decode_req,
  input  wire logic    busy,
  output bp_index_t    rd_index,
  input  bp_state_t    counter,
  input  btb_entry_t   btb,
  output prediction_t  prediction
);

  logic [bp_tag_bits-1:0] pc_tag;
  logic                   is_branch;
  logic                   btb_hit;
  logic                   cnt_taken;
  logic                   taken;

  assign rd_index = decode_req.pc[bp_index_lsb +: bp_index_bits];
  assign pc_tag   = decode_req.pc[bp_tag_lsb +: bp_tag_bits];

  assign is_branch = decode_req.valid && (decode_req.opcode == opcode_branch);
  assign btb_hit   = btb.valid && (btb.tag == pc_tag);   // same index, other tag is a miss
  assign cnt_taken = (counter == weak_taken) || (counter == strong_taken);

  // tables are being wiped, so no trust in their contents
  assign taken = is_branch && btb_hit && cnt_taken && !busy;

  always_comb begin
    prediction.taken = taken;
    if (taken) begin
      prediction.target = btb.target;
    end else begin
      prediction.target = decode_req.pc + 32'd4;   // fall through
    end
  end

endmodule

`default_nettype wire

// ==== verilog/bp_resolve.sv ====
`timescale 1ns/100ps
`default_nettype none

module bp_resolve import bp_pkg::*; (
  input  wire logic     clk,
  input  wire logic     arst_n,
  input  exec_resolve_t exec_resolve,
  input  wire logic     busy,
  output bp_index_t     rd_index,
  input  bp_state_t     counter,
  output redirect_t     redirect,
  output logic          cnt_wr_en,
  output bp_state_t     cnt_wr_entry,
  output logic          btb_wr_en,
  output btb_entry_t    btb_wr_entry,
  output bp_index_t     wr_index
);

  bp_index_t index;
  logic      branch_valid;
  logic      mispredict;
  bp_state_t cur_state;

  // last counter write, forwarded to a back-to-back resolution
  logic      prev_wr_valid;
  bp_index_t prev_wr_index;
  bp_state_t prev_wr_state;

  function automatic bp_state_t next_state(input bp_state_t state, input logic taken);
    bp_state_t nxt;
    case (state)
      strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
      weak_not_taken:   nxt = taken ? strong_taken : strong_not_taken;
      weak_taken:       nxt = taken ? strong_taken : strong_not_taken;   // no step back to 01
      default:          nxt = taken ? strong_taken : weak_taken;
    endcase
    return nxt;
  endfunction

  assign index    = exec_resolve.pc[bp_index_lsb +: bp_index_bits];
  assign rd_index = index;
  assign wr_index = index;

  assign branch_valid = exec_resolve.valid && exec_resolve.is_branch;

  // direction wrong, or right direction to the wrong place
  assign mispredict = branch_valid &&
                      ((exec_resolve.pred_taken != exec_resolve.actual_taken) ||
                       (exec_resolve.pred_taken && exec_resolve.actual_taken &&
                        (exec_resolve.pred_target != exec_resolve.actual_target)));

  always_comb begin
    redirect.flush = mispredict;
    if (exec_resolve.actual_taken) begin
      redirect.pc = exec_resolve.actual_target;
    end else begin
      redirect.pc = exec_resolve.pc + 32'd4;
    end
  end

  assign cur_state = (prev_wr_valid && (prev_wr_index == index)) ? prev_wr_state : counter;

  assign cnt_wr_en    = branch_valid && !busy;   // updates dropped during a sweep
  assign cnt_wr_entry = next_state(cur_state, exec_resolve.actual_taken);

  assign btb_wr_en           = cnt_wr_en && exec_resolve.actual_taken;
  assign btb_wr_entry.valid  = 1'b1;
  assign btb_wr_entry.tag    = exec_resolve.pc[bp_tag_lsb +: bp_tag_bits];
  assign btb_wr_entry.target = exec_resolve.actual_target;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prev_wr_valid <= 1'b0;
      prev_wr_index <= '0;
    end else begin
      prev_wr_valid <= cnt_wr_en;
      prev_wr_index <= index;
    end
  end

  always_ff @(posedge clk) begin
    if (cnt_wr_en) begin
      prev_wr_state <= cnt_wr_entry;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/bp_invalidate.sv ====
`timescale 1ns/100ps
`default_nettype none

module bp_invalidate import bp_pkg::*; (
  input  wire logic clk,
  input  wire logic arst_n,
  input  wire logic inv_req,
  output logic      inv_ack,
  output logic      busy,
  output logic      clr_en,
  output bp_index_t clr_index
);

  typedef enum logic [1:0] {
    st_idle  = 2'b00,
    st_sweep = 2'b01,
    st_done  = 2'b10
  } inv_state_t;

  inv_state_t state;
  bp_index_t  sweep_index;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= st_idle;
      sweep_index <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (inv_req && !inv_ack) begin
            state       <= st_sweep;
            sweep_index <= '0;
          end
        end
        st_sweep: begin
          sweep_index <= sweep_index + 1'b1;   // wraps back to 0 at the end
          if (sweep_index == bp_index_t'(bp_entries - 1)) begin
            state <= st_done;   // last entry cleared on this edge
          end
        end
        st_done: begin
          if (!inv_req) begin
            state <= st_idle;   // fourth phase of the handshake
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign inv_ack   = (state == st_done);
  assign busy      = (state == st_sweep);
  assign clr_en    = (state == st_sweep);
  assign clr_index = sweep_index;

endmodule

`default_nettype wire

// ==== verilog/branch_predictor.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_predictor import bp_pkg::*; (
  input  wire logic     clk,
  input  wire logic     arst_n,
  input  decode_req_t   decode_req,
  output prediction_t   prediction,
  input  exec_resolve_t exec_resolve,
  output redirect_t     redirect,
  input  wire logic     inv_req,
  output logic          inv_ack
);

  logic       busy;
  logic       clr_en;
  bp_index_t  clr_index;

  bp_index_t  lookup_index;
  bp_index_t  resolve_index;
  bp_state_t  cnt_rd_entry [2];   // 0 lookup, 1 resolve
  btb_entry_t btb_rd_entry [1];

  logic       cnt_wr_en;
  bp_state_t  cnt_wr_entry;
  logic       btb_wr_en;
  btb_entry_t btb_wr_entry;
  bp_index_t  wr_index;

  bp_table #(.entry_t(bp_state_t), .rd_ports(2)) cnt_table_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_index  ('{lookup_index, resolve_index}),
    .rd_entry  (cnt_rd_entry),
    .wr_en     (cnt_wr_en),
    .wr_index  (wr_index),
    .wr_entry  (cnt_wr_entry),
    .clr_en    (clr_en),
    .clr_index (clr_index)
  );

  bp_table #(.entry_t(btb_entry_t), .rd_ports(1)) btb_table_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_index  ('{lookup_index}),
    .rd_entry  (btb_rd_entry),
    .wr_en     (btb_wr_en),
    .wr_index  (wr_index),
    .wr_entry  (btb_wr_entry),
    .clr_en    (clr_en),
    .clr_index (clr_index)
  );

  bp_lookup bp_lookup_inst (
    .decode_req (decode_req),
    .busy       (busy),
    .rd_index   (lookup_index),
    .counter    (cnt_rd_entry[0]),
    .btb        (btb_rd_entry[0]),
    .prediction (prediction)
  );

  bp_resolve bp_resolve_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .exec_resolve (exec_resolve),
    .busy         (busy),
    .rd_index     (resolve_index),
    .counter      (cnt_rd_entry[1]),
    .redirect     (redirect),
    .cnt_wr_en    (cnt_wr_en),
    .cnt_wr_entry (cnt_wr_entry),
    .btb_wr_en    (btb_wr_en),
    .btb_wr_entry (btb_wr_entry),
    .wr_index     (wr_index)
  );

  bp_invalidate bp_invalidate_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .inv_req   (inv_req),
    .inv_ack   (inv_ack),
    .busy      (busy),
    .clr_en    (clr_en),
    .clr_index (clr_index)
  );

endmodule

`default_nettype wire

// ==== testbench/branch_predictor_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_predictor_properties import bp_pkg::*; (
  input wire logic    clk,
  input wire logic    arst_n,
  input decode_req_t  decode_req,
  input prediction_t  prediction,
  input exec_resolve_t exec_resolve,
  input redirect_t    redirect,
  input wire logic    inv_req,
  input wire logic    inv_ack
);

  int failures = 0;   // failed assertions so far

  // ack only drops once req is gone
  ack_falls_after_req: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(inv_ack) |-> !$past(inv_req))
    else begin
      failures++;
      $error("inv_ack dropped while inv_req was still high");
    end

  ack_rises_on_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(inv_ack) |-> $past(inv_req))
    else begin
      failures++;
      $error("inv_ack rose without a pending inv_req");
    end

  flush_needs_resolve: assert property (@(posedge clk) disable iff (!arst_n)
    redirect.flush |-> exec_resolve.valid)
    else begin
      failures++;
      $error("redirect.flush raised without a valid resolution");
    end

  taken_needs_branch: assert property (@(posedge clk) disable iff (!arst_n)
    prediction.taken |-> (decode_req.valid && (decode_req.opcode == opcode_branch)))
    else begin
      failures++;
      $error("prediction.taken raised for a non-branch or invalid request");
    end

endmodule

bind branch_predictor branch_predictor_properties branch_predictor_properties_inst (.*);

`default_nettype wire

// ==== testbench/branch_predictor_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_predictor_tb import bp_pkg::*; ();

  typedef struct packed {
    decode_req_t   req;
    exec_resolve_t res;
    prediction_t   exp_pred;
    redirect_t     exp_redir;
  } step_t;

  logic          clk;
  logic          arst_n;
  decode_req_t   decode_req;
  prediction_t   prediction;
  exec_resolve_t exec_resolve;
  redirect_t     redirect;
  logic          inv_req;
  logic          inv_ack;

  integer        seed = 32'hecb8_0403;
  step_t         steps [$];
  bp_state_t     model_cnt [bp_entries];   // reference counter table
  btb_entry_t    model_btb [bp_entries];   // reference target buffer

  branch_predictor branch_predictor_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .decode_req   (decode_req),
    .prediction   (prediction),
    .exec_resolve (exec_resolve),
    .redirect     (redirect),
    .inv_req      (inv_req),
    .inv_ack      (inv_ack)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  // the bound checker counts its failed assertions
  always @(branch_predictor_inst.branch_predictor_properties_inst.failures) begin
    if (branch_predictor_inst.branch_predictor_properties_inst.failures != 0) begin
      report_failure("an assertion on the DUT ports failed");
    end
  end

  task automatic check_prediction(input prediction_t expected);
    if (prediction !== expected) begin
      report_failure($sformatf("** Error at %0t: prediction taken=%0b target=%h, expected %0b %h",
                               $time, prediction.taken, prediction.target,
                               expected.taken, expected.target));
    end
  endtask

  task automatic check_redirect(input redirect_t expected);
    if ((redirect.flush !== expected.flush) ||
        (expected.flush && (redirect.pc !== expected.pc))) begin
      report_failure($sformatf("** Error at %0t: redirect flush=%0b pc=%h, expected %0b %h",
                               $time, redirect.flush, redirect.pc, expected.flush, expected.pc));
    end
  endtask

  // taken moves 00 to 01 and everything else to 11
  // not taken moves 11 to 10 and everything else to 00
  function automatic bp_state_t counter_after(input bp_state_t state, input logic taken);
    if (taken) begin
      return (state == strong_not_taken) ? weak_not_taken : strong_taken;
    end
    return (state == strong_taken) ? weak_taken : strong_not_taken;
  endfunction

  function automatic decode_req_t lookup_at(input logic [31:0] pc, input logic [6:0] opcode);
    decode_req_t r;
    r.valid  = 1'b1;
    r.pc     = pc;
    r.opcode = opcode;
    return r;
  endfunction

  function automatic exec_resolve_t outcome_at(input logic [31:0] pc, input logic taken,
                                               input logic [31:0] target, input logic pred_taken,
                                               input logic [31:0] pred_target);
    exec_resolve_t r;
    r.valid         = 1'b1;
    r.pc            = pc;
    r.is_branch     = 1'b1;
    r.actual_taken  = taken;
    r.actual_target = target;
    r.pred_taken    = pred_taken;
    r.pred_target   = pred_target;
    return r;
  endfunction

  task automatic add_step(input decode_req_t req, input exec_resolve_t res);
    step_t s;
    s           = '0;
    s.req       = req;
    s.res       = res;
    steps.push_back(s);
  endtask

  task automatic clear_model();
    for (int i = 0; i < bp_entries; i++) begin
      model_cnt[i] = strong_not_taken;
      model_btb[i] = '0;
    end
  endtask

  // lookup sees the tables before the same-cycle update
  task automatic fill_expected(input int first);
    step_t            s;
    logic [7:0]       idx;
    logic             hit;
    logic             miss;
    for (int i = first; i < steps.size(); i++) begin
      s   = steps[i];
      idx = s.req.pc[9:2];
      hit = model_btb[idx].valid && (model_btb[idx].tag == s.req.pc[31:10]);
      s.exp_pred.taken  = s.req.valid && (s.req.opcode == opcode_branch) && hit &&
                          ((model_cnt[idx] == weak_taken) || (model_cnt[idx] == strong_taken));
      s.exp_pred.target = s.exp_pred.taken ? model_btb[idx].target : s.req.pc + 32'd4;
      miss = (s.res.pred_taken != s.res.actual_taken) ||
             (s.res.actual_taken && (s.res.pred_target != s.res.actual_target));
      s.exp_redir.flush = s.res.valid && s.res.is_branch && miss;
      s.exp_redir.pc    = s.res.actual_taken ? s.res.actual_target : s.res.pc + 32'd4;
      if (s.res.valid && s.res.is_branch) begin
        idx            = s.res.pc[9:2];
        model_cnt[idx] = counter_after(model_cnt[idx], s.res.actual_taken);
        if (s.res.actual_taken) begin
          model_btb[idx] = {1'b1, s.res.pc[31:10], s.res.actual_target};
        end
      end
      steps[i] = s;
    end
  endtask

  task automatic run_steps(input int first);
    for (int i = first; i < steps.size(); i++) begin
      @(negedge clk);
      decode_req   = steps[i].req;
      exec_resolve = steps[i].res;
      #9;   // just ahead of the rising edge
      check_prediction(steps[i].exp_pred);
      check_redirect(steps[i].exp_redir);
    end
    @(negedge clk);
    decode_req   = '0;
    exec_resolve = '0;
  endtask

  task automatic invalidate_tables();
    int cycles;
    @(negedge clk);
    inv_req = 1'b1;
    cycles  = 0;
    while (inv_ack !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > 300) report_failure("inv_ack did not rise within 300 cycles of inv_req");
    end
    inv_req = 1'b0;
    cycles  = 0;
    while (inv_ack !== 1'b0) begin
      @(negedge clk);
      cycles++;
      if (cycles > 300) report_failure("inv_ack did not fall within 300 cycles of inv_req low");
    end
  endtask

  initial begin
    logic [31:0]   pc_a;
    logic [31:0]   tgt_a;
    logic [31:0]   pc_r;
    logic [31:0]   pc_t [3];
    exec_resolve_t res;
    int            first;
    arst_n       = 1'b0;
    decode_req   = '0;
    exec_resolve = '0;
    inv_req      = 1'b0;
    clear_model();
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    for (int k = 0; k < 4; k++) begin   // cold tables
      pc_r = $random(seed) & 32'hffff_fffc;
      add_step(lookup_at(pc_r, opcode_branch), '0);
    end
    pc_a  = $random(seed) & 32'hffff_fffc;
    tgt_a = $random(seed) & 32'hffff_fffc;
    add_step(lookup_at(pc_a, opcode_branch), outcome_at(pc_a, 1'b1, tgt_a, 1'b0, pc_a + 4));
    add_step(lookup_at(pc_a, opcode_branch), outcome_at(pc_a, 1'b1, tgt_a, 1'b0, pc_a + 4));
    add_step(lookup_at(pc_a, opcode_branch), '0);
    add_step(lookup_at(pc_a, opcode_branch), outcome_at(pc_a, 1'b1, tgt_a, 1'b1, tgt_a));
    add_step(lookup_at(pc_a, 7'b0110011), outcome_at(pc_a, 1'b1, tgt_a, 1'b1, tgt_a + 8));
    res           = outcome_at(pc_a, 1'b0, pc_a + 4, 1'b1, tgt_a);
    res.is_branch = 1'b0;   // not a branch so no flush and no update
    add_step(lookup_at(pc_a ^ 32'h0000_0400, opcode_branch), res);
    add_step(lookup_at(pc_a, opcode_branch), outcome_at(pc_a, 1'b0, pc_a + 4, 1'b1, tgt_a));
    add_step(lookup_at(pc_a, opcode_branch), outcome_at(pc_a, 1'b0, pc_a + 4, 1'b1, tgt_a));
    add_step(lookup_at(pc_a, opcode_branch), outcome_at(pc_a, 1'b1, tgt_a, 1'b0, pc_a + 4));
    add_step(lookup_at(pc_a, opcode_branch), outcome_at(pc_a, 1'b1, tgt_a, 1'b0, pc_a + 4));
    add_step(lookup_at(pc_a, opcode_branch), '0);
    for (int k = 0; k < 3; k++) begin
      pc_t[k] = $random(seed) & 32'hffff_fffc;
      pc_r    = $random(seed) & 32'hffff_fffc;
      add_step('0, outcome_at(pc_t[k], 1'b1, pc_r, 1'b0, pc_t[k] + 4));
      add_step('0, outcome_at(pc_t[k], 1'b1, pc_r, 1'b0, pc_t[k] + 4));
      add_step(lookup_at(pc_t[k], opcode_branch), '0);
    end
    fill_expected(0);
    run_steps(0);

    invalidate_tables();
    clear_model();
    first = steps.size();
    add_step(lookup_at(pc_a, opcode_branch), '0);
    for (int k = 0; k < 3; k++) begin
      add_step(lookup_at(pc_t[k], opcode_branch), '0);
    end
    add_step(lookup_at(pc_a, opcode_branch), outcome_at(pc_a, 1'b1, tgt_a, 1'b0, pc_a + 4));
    add_step(lookup_at(pc_a, opcode_branch), '0);
    fill_expected(first);
    run_steps(first);

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== branch_predictor.f ====
verilog/bp_pkg.sv
verilog/bp_table.sv
verilog/bp_lookup.sv
verilog/bp_resolve.sv
verilog/bp_invalidate.sv
verilog/branch_predictor.sv
testbench/branch_predictor_properties.sv
testbench/branch_predictor_tb.sv
